//--- include/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath widths
`define CPU_DATA_W 8
`define CPU_PC_W 16

// Memory is 8 KB, so addresses keep 13 bits
`define CPU_RAM_AW 13
`define CPU_RAM_MASK 16'h1FFF

// First opcode is fetched from here after reset
`define CPU_RESET_PC 16'h0200

// Read data returns this many edges after the address is presented
`define CPU_MEM_LAT 2

// Opcodes and opcode fields
`define CPU_OP_JMP_ABS 8'h4C
`define CPU_LOAD_GROUP 3'd5

`endif

//--- hdl/cpu_isa_pkg.sv
`include "cpu_consts.svh"

package cpu_isa_pkg;

  // 6502 opcode layout aaa_bbb_cc
  typedef struct packed {
    logic [2:0] grp;
    logic [2:0] mode;
    logic [1:0] cls;
  } opcode_fields_t;

  // Same byte seen raw or split into fields
  typedef union packed {
    logic [`CPU_DATA_W-1:0] raw;
    opcode_fields_t         f;
  } opcode_t;

  typedef enum logic [2:0] {
    MODE_IMM,
    MODE_ZP,
    MODE_ZP_IDX,
    MODE_ABS,
    MODE_ABS_IDX,
    MODE_JUMP,
    MODE_NONE
  } addr_mode_t;

  // Load target, also used to name the index register
  typedef enum logic [1:0] {
    REG_A,
    REG_X,
    REG_Y
  } reg_sel_t;

endpackage

//--- hdl/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

  // One memory byte takes req, wait and recv
  typedef enum logic [1:0] {
    SEQ_REQ,
    SEQ_WAIT,
    SEQ_RECV,
    SEQ_EXEC
  } seq_state_t;

  // Which byte of the instruction is in flight
  typedef enum logic [1:0] {
    FETCH_OPCODE,
    FETCH_OPERAND_LO,
    FETCH_OPERAND_HI,
    FETCH_DATA
  } fetch_stage_t;

endpackage

//--- hdl/opcode_decoder.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module opcode_decoder (
  input  cpu_isa_pkg::opcode_t    opcode,
  output cpu_isa_pkg::addr_mode_t mode,
  output cpu_isa_pkg::reg_sel_t   target,
  output cpu_isa_pkg::reg_sel_t   index,
  output logic [1:0]              length
);

  always_comb begin
    mode   = cpu_isa_pkg::MODE_NONE;
    target = cpu_isa_pkg::REG_A;
    index  = cpu_isa_pkg::REG_X;

    if (opcode.raw == `CPU_OP_JMP_ABS) begin
      mode = cpu_isa_pkg::MODE_JUMP;
    end else if (opcode.f.grp == `CPU_LOAD_GROUP) begin
      // cls picks the register, LDX indexes with Y
      case (opcode.f.cls)
        2'b01: target = cpu_isa_pkg::REG_A;
        2'b10: begin
          target = cpu_isa_pkg::REG_X;
          index  = cpu_isa_pkg::REG_Y;
        end
        2'b00: target = cpu_isa_pkg::REG_Y;
        default: ;
      endcase

      if (opcode.f.cls != 2'b11) begin
        case (opcode.f.mode)
          3'b000: begin
            // LDA (zp,X) is not supported
            if (opcode.f.cls != 2'b01) mode = cpu_isa_pkg::MODE_IMM;
          end
          3'b001: mode = cpu_isa_pkg::MODE_ZP;
          3'b010: begin
            // TAX and TAY share this slot
            if (opcode.f.cls == 2'b01) mode = cpu_isa_pkg::MODE_IMM;
          end
          3'b011: mode = cpu_isa_pkg::MODE_ABS;
          3'b101: mode = cpu_isa_pkg::MODE_ZP_IDX;
          3'b110: begin
            // Only LDA abs,Y lives here
            if (opcode.f.cls == 2'b01) begin
              mode  = cpu_isa_pkg::MODE_ABS_IDX;
              index = cpu_isa_pkg::REG_Y;
            end
          end
          3'b111: mode = cpu_isa_pkg::MODE_ABS_IDX;
          default: ;
        endcase
      end
    end

    // Instruction size in bytes
    case (mode)
      cpu_isa_pkg::MODE_IMM,
      cpu_isa_pkg::MODE_ZP,
      cpu_isa_pkg::MODE_ZP_IDX: length = 2'd2;
      cpu_isa_pkg::MODE_ABS,
      cpu_isa_pkg::MODE_ABS_IDX,
      cpu_isa_pkg::MODE_JUMP:   length = 2'd3;
      default:                  length = 2'd1;
    endcase
  end

endmodule

//--- hdl/cpu_sequencer.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_sequencer (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`CPU_DATA_W-1:0]  mem_rdata,
  input  cpu_isa_pkg::addr_mode_t mode,
  input  cpu_isa_pkg::reg_sel_t   target,
  input  cpu_isa_pkg::reg_sel_t   index,
  input  logic [1:0]              length,
  input  logic [`CPU_DATA_W-1:0]  reg_x,
  input  logic [`CPU_DATA_W-1:0]  reg_y,
  output logic [`CPU_RAM_AW-1:0]  mem_addr,
  output cpu_isa_pkg::opcode_t    opcode,
  output logic [`CPU_PC_W-1:0]    pc,
  output logic                    load_en,
  output logic [`CPU_DATA_W-1:0]  load_data,
  output cpu_isa_pkg::reg_sel_t   load_target,
  output logic                    retire
);

  cpu_ctrl_pkg::seq_state_t   state;
  cpu_ctrl_pkg::fetch_stage_t stage;
  cpu_isa_pkg::opcode_t       opcode_q;
  logic [`CPU_DATA_W-1:0]     operand_lo;
  logic [`CPU_DATA_W-1:0]     operand_hi;
  logic [`CPU_DATA_W-1:0]     data_q;

  logic                       opcode_recv;
  logic [`CPU_PC_W-1:0]       pc_plus1;
  logic [`CPU_PC_W-1:0]       pc_plus2;
  logic [`CPU_PC_W-1:0]       pc_step;
  logic [`CPU_PC_W-1:0]       pc_next;
  logic [`CPU_PC_W-1:0]       operand_word;
  logic [`CPU_DATA_W-1:0]     index_val;
  logic [`CPU_DATA_W-1:0]     zp_sum;
  logic [`CPU_PC_W-1:0]       abs_sum;
  logic [`CPU_RAM_AW-1:0]     eff_addr;

  assign opcode_recv = (state == cpu_ctrl_pkg::SEQ_RECV) &&
                       (stage == cpu_ctrl_pkg::FETCH_OPCODE);

  // Decoder sees the arriving byte while it is being received
  assign opcode.raw = opcode_recv ? mem_rdata : opcode_q.raw;

  assign pc_plus1 = pc + `CPU_PC_W'd1;
  assign pc_plus2 = pc + `CPU_PC_W'd2;
  assign pc_step  = pc + {{(`CPU_PC_W-2){1'b0}}, length};
  assign pc_next  = ((mode == cpu_isa_pkg::MODE_JUMP) ? {operand_hi, operand_lo} : pc_step)
                    & `CPU_RAM_MASK;

  // Last operand byte is still on mem_rdata when the data address is formed
  assign operand_word = (stage == cpu_ctrl_pkg::FETCH_OPERAND_HI) ?
                        {mem_rdata, operand_lo} :
                        {{(`CPU_PC_W-`CPU_DATA_W){1'b0}}, mem_rdata};

  assign index_val = (index == cpu_isa_pkg::REG_Y) ? reg_y : reg_x;
  assign zp_sum    = operand_word[`CPU_DATA_W-1:0] + index_val;
  assign abs_sum   = operand_word + {{(`CPU_PC_W-`CPU_DATA_W){1'b0}}, index_val};

  always_comb begin
    case (mode)
      cpu_isa_pkg::MODE_ZP:
        eff_addr = {{(`CPU_RAM_AW-`CPU_DATA_W){1'b0}}, operand_word[`CPU_DATA_W-1:0]};
      // Zero page index wraps inside page zero
      cpu_isa_pkg::MODE_ZP_IDX:
        eff_addr = {{(`CPU_RAM_AW-`CPU_DATA_W){1'b0}}, zp_sum};
      cpu_isa_pkg::MODE_ABS_IDX:
        eff_addr = abs_sum[`CPU_RAM_AW-1:0];
      default:
        eff_addr = operand_word[`CPU_RAM_AW-1:0];
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= cpu_ctrl_pkg::SEQ_REQ;
      stage    <= cpu_ctrl_pkg::FETCH_OPCODE;
      pc       <= `CPU_RESET_PC;
      mem_addr <= `CPU_RAM_AW'(`CPU_RESET_PC);
      opcode_q <= '0;
    end else begin
      case (state)
        cpu_ctrl_pkg::SEQ_REQ:  state <= cpu_ctrl_pkg::SEQ_WAIT;
        cpu_ctrl_pkg::SEQ_WAIT: state <= cpu_ctrl_pkg::SEQ_RECV;
        cpu_ctrl_pkg::SEQ_RECV: begin
          state <= cpu_ctrl_pkg::SEQ_REQ;
          case (stage)
            cpu_ctrl_pkg::FETCH_OPCODE: begin
              opcode_q <= opcode;
              if (mode == cpu_isa_pkg::MODE_NONE) begin
                // Unknown opcode retires right here
                pc       <= pc_next;
                mem_addr <= pc_next[`CPU_RAM_AW-1:0];
              end else begin
                stage    <= cpu_ctrl_pkg::FETCH_OPERAND_LO;
                mem_addr <= pc_plus1[`CPU_RAM_AW-1:0];
              end
            end
            cpu_ctrl_pkg::FETCH_OPERAND_LO: begin
              operand_lo <= mem_rdata;
              case (mode)
                cpu_isa_pkg::MODE_IMM: state <= cpu_ctrl_pkg::SEQ_EXEC;
                cpu_isa_pkg::MODE_ABS,
                cpu_isa_pkg::MODE_ABS_IDX,
                cpu_isa_pkg::MODE_JUMP: begin
                  stage    <= cpu_ctrl_pkg::FETCH_OPERAND_HI;
                  mem_addr <= pc_plus2[`CPU_RAM_AW-1:0];
                end
                default: begin
                  stage    <= cpu_ctrl_pkg::FETCH_DATA;
                  mem_addr <= eff_addr;
                end
              endcase
            end
            cpu_ctrl_pkg::FETCH_OPERAND_HI: begin
              operand_hi <= mem_rdata;
              if (mode == cpu_isa_pkg::MODE_JUMP) begin
                state <= cpu_ctrl_pkg::SEQ_EXEC;
              end else begin
                stage    <= cpu_ctrl_pkg::FETCH_DATA;
                mem_addr <= eff_addr;
              end
            end
            default: begin
              data_q <= mem_rdata;
              state  <= cpu_ctrl_pkg::SEQ_EXEC;
            end
          endcase
        end
        default: begin
          // Exec, move on to the next opcode
          pc       <= pc_next;
          mem_addr <= pc_next[`CPU_RAM_AW-1:0];
          stage    <= cpu_ctrl_pkg::FETCH_OPCODE;
          state    <= cpu_ctrl_pkg::SEQ_REQ;
        end
      endcase
    end
  end

  assign load_en     = (state == cpu_ctrl_pkg::SEQ_EXEC) && (mode != cpu_isa_pkg::MODE_JUMP);
  assign load_data   = (mode == cpu_isa_pkg::MODE_IMM) ? operand_lo : data_q;
  assign load_target = target;
  assign retire      = (state == cpu_ctrl_pkg::SEQ_EXEC) ||
                       (opcode_recv && (mode == cpu_isa_pkg::MODE_NONE));

endmodule

//--- hdl/reg_writeback.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module reg_writeback (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   load_en,
  input  logic [`CPU_DATA_W-1:0] load_data,
  input  cpu_isa_pkg::reg_sel_t  load_target,
  output logic [`CPU_DATA_W-1:0] reg_a,
  output logic [`CPU_DATA_W-1:0] reg_x,
  output logic [`CPU_DATA_W-1:0] reg_y,
  output logic                   flag_z,
  output logic                   flag_n
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reg_a <= '0;
      reg_x <= '0;
      reg_y <= '0;
    end else if (load_en) begin
      case (load_target)
        cpu_isa_pkg::REG_X: reg_x <= load_data;
        cpu_isa_pkg::REG_Y: reg_y <= load_data;
        default:            reg_a <= load_data;
      endcase
    end
  end

  // Flags follow the loaded value whatever the target
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flag_z <= 1'b0;
      flag_n <= 1'b0;
    end else if (load_en) begin
      flag_z <= (load_data == '0);
      flag_n <= load_data[`CPU_DATA_W-1];
    end
  end

endmodule

//--- hdl/cpu_top.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`CPU_DATA_W-1:0] mem_rdata,
  output logic [`CPU_RAM_AW-1:0] mem_addr,
  output logic [`CPU_PC_W-1:0]   pc,
  output logic [`CPU_DATA_W-1:0] reg_a,
  output logic [`CPU_DATA_W-1:0] reg_x,
  output logic [`CPU_DATA_W-1:0] reg_y,
  output logic                   flag_z,
  output logic                   flag_n,
  output logic                   retire
);

  cpu_isa_pkg::opcode_t    opcode;
  cpu_isa_pkg::addr_mode_t mode;
  cpu_isa_pkg::reg_sel_t   target;
  cpu_isa_pkg::reg_sel_t   index;
  logic [1:0]              length;
  logic                    load_en;
  logic [`CPU_DATA_W-1:0]  load_data;
  cpu_isa_pkg::reg_sel_t   load_target;

  opcode_decoder u_decoder (
    .opcode (opcode),
    .mode   (mode),
    .target (target),
    .index  (index),
    .length (length)
  );

  // Index values come back from the register file
  cpu_sequencer u_sequencer (
    .clk         (clk),
    .rst_n       (rst_n),
    .mem_rdata   (mem_rdata),
    .mode        (mode),
    .target      (target),
    .index       (index),
    .length      (length),
    .reg_x       (reg_x),
    .reg_y       (reg_y),
    .mem_addr    (mem_addr),
    .opcode      (opcode),
    .pc          (pc),
    .load_en     (load_en),
    .load_data   (load_data),
    .load_target (load_target),
    .retire      (retire)
  );

  reg_writeback u_writeback (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_en     (load_en),
    .load_data   (load_data),
    .load_target (load_target),
    .reg_a       (reg_a),
    .reg_x       (reg_x),
    .reg_y       (reg_y),
    .flag_z      (flag_z),
    .flag_n      (flag_n)
  );

endmodule

//--- verif/cpu_asserts.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_asserts (
  input logic                     clk,
  input logic                     rst_n,
  input cpu_ctrl_pkg::seq_state_t state,
  input logic [`CPU_RAM_AW-1:0]   mem_addr,
  input logic                     load_en,
  input logic                     retire
);

  // Retire never spans two cycles
  retire_single: assert property (@(posedge clk) disable iff (!rst_n)
    retire |=> !retire)
    else $error("retire stayed high for more than one cycle");

  // Address presented in req holds until the byte is received
  addr_hold_wait: assert property (@(posedge clk) disable iff (!rst_n)
    (state == cpu_ctrl_pkg::SEQ_WAIT) |-> $stable(mem_addr))
    else $error("mem_addr changed between req and wait");

  addr_hold_recv: assert property (@(posedge clk) disable iff (!rst_n)
    (state == cpu_ctrl_pkg::SEQ_RECV) |-> $stable(mem_addr))
    else $error("mem_addr changed between wait and recv");

  load_with_retire: assert property (@(posedge clk) disable iff (!rst_n)
    load_en |-> retire)
    else $error("load_en seen without retire");

endmodule

bind cpu_sequencer cpu_asserts u_asserts (
  .clk      (clk),
  .rst_n    (rst_n),
  .state    (state),
  .mem_addr (mem_addr),
  .load_en  (load_en),
  .retire   (retire)
);

//--- verif/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_tb;

  localparam int NUM_ROWS     = 30;
  localparam int RESET_CYCLES = 16;
  // Longest instruction reads four bytes and then executes
  localparam int INSN_CYCLES_MAX = 4 * (`CPU_MEM_LAT + 1) + 1;
  localparam int RETIRE_LIMIT = INSN_CYCLES_MAX * 4;
  localparam int MEM_BYTES    = 1 << `CPU_RAM_AW;

  // Load target of a row where RN means the row loads nothing
  localparam logic [1:0] RA = 2'd0;
  localparam logic [1:0] RX = 2'd1;
  localparam logic [1:0] RY = 2'd2;
  localparam logic [1:0] RN = 2'd3;

  logic                   clk;
  logic                   rst_n;
  logic [`CPU_DATA_W-1:0] mem_rdata;
  logic [`CPU_RAM_AW-1:0] mem_addr;
  logic [`CPU_PC_W-1:0]   pc;
  logic [`CPU_DATA_W-1:0] reg_a;
  logic [`CPU_DATA_W-1:0] reg_x;
  logic [`CPU_DATA_W-1:0] reg_y;
  logic                   flag_z;
  logic                   flag_n;
  logic                   retire;

  logic [`CPU_DATA_W-1:0] mem [MEM_BYTES];
  logic [`CPU_DATA_W-1:0] read_pipe;
  logic [`CPU_RAM_AW-1:0] read_addr;

  // Test table with one entry per instruction
  string                  name_t [NUM_ROWS];
  logic [23:0]            code_t [NUM_ROWS];
  logic [`CPU_RAM_AW-1:0] ea_t   [NUM_ROWS];
  logic [7:0]             data_t [NUM_ROWS];
  logic [1:0]             tgt_t  [NUM_ROWS];
  logic [7:0]             val_t  [NUM_ROWS];
  logic [1:0]             zn_t   [NUM_ROWS];
  logic [`CPU_PC_W-1:0]   pc_t   [NUM_ROWS];
  int                     cyc_t  [NUM_ROWS];

  int                     row_count;
  int                     row_errors;
  int                     tests_run;
  int                     tests_failed;
  string                  cur_name;
  logic [`CPU_PC_W-1:0]   cur_pc;
  logic [7:0]             exp_a;
  logic [7:0]             exp_x;
  logic [7:0]             exp_y;

  cpu_top u_cpu_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_rdata (mem_rdata),
    .mem_addr  (mem_addr),
    .pc        (pc),
    .reg_a     (reg_a),
    .reg_x     (reg_x),
    .reg_y     (reg_y),
    .flag_z    (flag_z),
    .flag_n    (flag_n),
    .retire    (retire)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Two edge read pipeline that takes the address as it stood before the edge
  always begin
    @(posedge clk);
    read_addr = mem_addr;
    #1;
    mem_rdata = read_pipe;
    read_pipe = mem[read_addr];
  end

  initial begin
    repeat (RESET_CYCLES + NUM_ROWS * RETIRE_LIMIT) @(posedge clk);
    $display("watchdog expired before the test table finished");
    $display("tests failed");
    $finish;
  end

  task automatic add_row(input string nm, input logic [23:0] code,
                         input logic [`CPU_RAM_AW-1:0] ea, input logic [7:0] data,
                         input logic [1:0] tgt, input logic [7:0] val,
                         input logic [1:0] zn, input logic [15:0] npc, input int cyc);
    name_t[row_count] = nm;
    code_t[row_count] = code;
    ea_t[row_count]   = ea;
    data_t[row_count] = data;
    tgt_t[row_count]  = tgt;
    val_t[row_count]  = val;
    zn_t[row_count]   = zn;
    pc_t[row_count]   = npc;
    cyc_t[row_count]  = cyc;
    row_count++;
  endtask

  // Instruction bytes go at the current PC and the data byte at its address
  task automatic place_row(input int i);
    logic [`CPU_RAM_AW-1:0] base;
    base = cur_pc[`CPU_RAM_AW-1:0];
    mem[base]         = code_t[i][23:16];
    mem[base + 13'd1] = code_t[i][15:8];
    mem[base + 13'd2] = code_t[i][7:0];
    mem[ea_t[i]]      = data_t[i];
  endtask

  task automatic check_val(input string what, input logic [15:0] expv,
                           input logic [15:0] gotv);
    assert (gotv === expv) else begin
      $display("ERROR %s: %s expected %h, got %h", cur_name, what, expv, gotv);
      row_errors++;
    end
  endtask

  task automatic wait_retire(output int cycles, output bit seen);
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < RETIRE_LIMIT) begin
      @(negedge clk);
      cycles++;
      if (retire) seen = 1'b1;
    end
  endtask

  task automatic check_state(input logic [1:0] zn, input logic [15:0] npc);
    check_val("reg_a", 16'(exp_a), 16'(reg_a));
    check_val("reg_x", 16'(exp_x), 16'(reg_x));
    check_val("reg_y", 16'(exp_y), 16'(reg_y));
    check_val("flag_z", 16'(zn[1]), 16'(flag_z));
    check_val("flag_n", 16'(zn[0]), 16'(flag_n));
    check_val("pc", npc, pc);
    check_val("mem_addr", 16'(npc[`CPU_RAM_AW-1:0]), 16'(mem_addr));
  endtask

  initial begin
    int cycles;
    bit seen;
    bit aborted;
    rst_n        = 1'b0;
    mem_rdata    = '0;
    read_pipe    = '0;
    row_count    = 0;
    tests_run    = 0;
    tests_failed = 0;
    aborted      = 1'b0;
    exp_a        = 8'h00;
    exp_x        = 8'h00;
    exp_y        = 8'h00;
    cur_pc       = `CPU_RESET_PC;
    void'($urandom(98));
    for (int i = 0; i < MEM_BYTES; i++) mem[i] = 8'($urandom);

    // Name, bytes, data address, data, target, value, {Z,N}, next PC, cycles
    add_row("lda_imm_00",   24'hA90000, 13'h1FFF, 8'h00, RA, 8'h00, 2'b10, 16'h0202, 7);
    add_row("lda_imm_80",   24'hA98000, 13'h1FFF, 8'h00, RA, 8'h80, 2'b01, 16'h0204, 7);
    add_row("lda_imm_7f",   24'hA97F00, 13'h1FFF, 8'h00, RA, 8'h7F, 2'b00, 16'h0206, 7);
    add_row("ldx_imm_80",   24'hA28000, 13'h1FFF, 8'h00, RX, 8'h80, 2'b01, 16'h0208, 7);
    add_row("ldx_imm_00",   24'hA20000, 13'h1FFF, 8'h00, RX, 8'h00, 2'b10, 16'h020A, 7);
    add_row("ldy_imm_7f",   24'hA07F00, 13'h1FFF, 8'h00, RY, 8'h7F, 2'b00, 16'h020C, 7);
    add_row("ldy_imm_00",   24'hA00000, 13'h1FFF, 8'h00, RY, 8'h00, 2'b10, 16'h020E, 7);
    add_row("ldy_imm_80",   24'hA08000, 13'h1FFF, 8'h00, RY, 8'h80, 2'b01, 16'h0210, 7);
    add_row("ldx_imm_f0",   24'hA2F000, 13'h1FFF, 8'h00, RX, 8'hF0, 2'b01, 16'h0212, 7);
    add_row("lda_zp",       24'hA54000, 13'h0040, 8'h5A, RA, 8'h5A, 2'b00, 16'h0214, 10);
    add_row("lda_zpx_wrap", 24'hB52000, 13'h0010, 8'hC3, RA, 8'hC3, 2'b01, 16'h0216, 10);
    add_row("ldy_zpx",      24'hB40500, 13'h00F5, 8'h00, RY, 8'h00, 2'b10, 16'h0218, 10);
    add_row("ldy_zp",       24'hA43300, 13'h0033, 8'h91, RY, 8'h91, 2'b01, 16'h021A, 10);
    add_row("ldx_zp",       24'hA67700, 13'h0077, 8'h12, RX, 8'h12, 2'b00, 16'h021C, 10);
    add_row("ldx_zpy_wrap", 24'hB68000, 13'h0011, 8'h80, RX, 8'h80, 2'b01, 16'h021E, 10);
    add_row("lda_abs",      24'hAD3412, 13'h1234, 8'h3C, RA, 8'h3C, 2'b00, 16'h0221, 13);
    add_row("lda_absx",     24'hBD0010, 13'h1080, 8'h00, RA, 8'h00, 2'b10, 16'h0224, 13);
    add_row("lda_absy",     24'hB9F010, 13'h1181, 8'hFE, RA, 8'hFE, 2'b01, 16'h0227, 13);
    add_row("ldx_abs",      24'hAE5614, 13'h1456, 8'h21, RX, 8'h21, 2'b00, 16'h022A, 13);
    add_row("ldx_absy",     24'hBE0015, 13'h1591, 8'h99, RX, 8'h99, 2'b01, 16'h022D, 13);
    add_row("ldy_abs",      24'hAC8016, 13'h1680, 8'h01, RY, 8'h01, 2'b00, 16'h0230, 13);
    add_row("ldy_absx",     24'hBCFF16, 13'h1798, 8'h00, RY, 8'h00, 2'b10, 16'h0233, 13);
    add_row("lda_abs_mask", 24'hAD00F1, 13'h1100, 8'h77, RA, 8'h77, 2'b00, 16'h0236, 13);
    add_row("nop_ea",       24'hEA0000, 13'h1FFF, 8'h00, RN, 8'h00, 2'b00, 16'h0237, 3);
    add_row("nop_02",       24'h020000, 13'h1FFF, 8'h00, RN, 8'h00, 2'b00, 16'h0238, 3);
    add_row("jmp_abs",      24'h4C00E4, 13'h1FFF, 8'h00, RN, 8'h00, 2'b00, 16'h0400, 10);
    add_row("ldy_imm_tgt",  24'hA00000, 13'h1FFF, 8'h00, RY, 8'h00, 2'b10, 16'h0402, 7);
    add_row("jmp_back",     24'h4C0003, 13'h1FFF, 8'h00, RN, 8'h00, 2'b10, 16'h0300, 10);
    add_row("nop_ff",       24'hFF0000, 13'h1FFF, 8'h00, RN, 8'h00, 2'b10, 16'h0301, 3);
    add_row("ldx_imm_7f",   24'hA27F00, 13'h1FFF, 8'h00, RX, 8'h7F, 2'b00, 16'h0303, 7);

    place_row(0);
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;
    #1;
    cur_name   = "reset";
    row_errors = 0;
    check_state(2'b00, `CPU_RESET_PC);
    check_val("retire", 16'h0000, 16'(retire));
    tests_run++;
    if (row_errors != 0) tests_failed++;
    $display("%s reset", (row_errors == 0) ? "PASS" : "FAIL");

    for (int i = 0; i < NUM_ROWS && !aborted; i++) begin
      cur_name   = name_t[i];
      row_errors = 0;
      wait_retire(cycles, seen);
      tests_run++;
      if (!seen) begin
        $display("no retire from %s within %0d cycles", name_t[i], RETIRE_LIMIT);
        tests_failed++;
        aborted = 1'b1;
      end else begin
        @(posedge clk);
        #2;
        case (tgt_t[i])
          RA: exp_a = val_t[i];
          RX: exp_x = val_t[i];
          RY: exp_y = val_t[i];
          default: ;
        endcase
        check_state(zn_t[i], pc_t[i]);
        check_val("cycles", 16'(cyc_t[i]), 16'(cycles));
        if (row_errors != 0) tests_failed++;
        $display("%s %s, %0d cycles", (row_errors == 0) ? "PASS" : "FAIL", name_t[i], cycles);
        cur_pc = pc_t[i];
        if (i + 1 < NUM_ROWS) place_row(i + 1);
      end
    end

    $display("%0d tests run, %0d passed, %0d failed",
             tests_run, tests_run - tests_failed, tests_failed);
    if (tests_failed == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+include
hdl/cpu_isa_pkg.sv
hdl/cpu_ctrl_pkg.sv
hdl/opcode_decoder.sv
hdl/cpu_sequencer.sv
hdl/reg_writeback.sv
hdl/cpu_top.sv
verif/cpu_asserts.sv
verif/cpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := cpu_tb
FLIST     := flist.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation FAILED, see $(LOG)"; exit 1)
	@echo "simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
